/* Makefile */
TOOL     = verilator
FLAGS    = --timing --assert
TOP      = pdp8Tb
FILELIST = tb.f
OBJDIR   = obj_dir
LOG      = sim.log

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Errors found" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "No errors" $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)

/* tb.f */
verilog/pdp8Pkg.sv
verilog/coreMemory.sv
verilog/memRefUnit.sv
verilog/operateUnit.sv
verilog/panelSwitches.sv
verilog/cpuSequencer.sv
verilog/pdp8Top.sv
testbench/pdp8Top_checker.sv
testbench/pdp8Tb.sv

/* testbench/pdp8Tb.sv */
// PDP-8 core testbench: console deposit and examine, table-driven programs, continue and stop
`timescale 1ns/1ns

module pdp8Tb import pdp8Pkg::*; ();

    // one program test: words from 0200, start address, operand at 0300, expected results
    typedef struct packed {
        word_t [0:7] prog;
        word_t       start;
        word_t       operand;
        word_t       sr;                    // switch register while running, for OSR
        acLink_t     expAcLink;
        word_t       expMem;                // word at 0300 after the halt
    } progRow_t;

    localparam int           numRows = 19;
    localparam word_t        hlt     = 12'o7402;
    localparam panelSwitch_t swStart = 7'b1000000;
    localparam panelSwitch_t swCont  = 7'b0100000;
    localparam panelSwitch_t swLdad  = 7'b0010000;
    localparam panelSwitch_t swExam  = 7'b0001000;
    localparam panelSwitch_t swDep   = 7'b0000100;
    localparam panelSwitch_t swStop  = 7'b0000010;

    logic         CLOCK;
    logic         RESET;
    panelSwitch_t switches;
    word_t        switchReg;
    frontLamps_t  lamps;
    frontLamps_t  stopLamps;                // expected panel after the stop switch
    progRow_t     tbl [0:numRows-1];
    word_t        randWords [0:7];
    integer       seed;
    int           errors, testErrors, tests, failedTests;

    pdp8Top #(.DEBOUNCE_BITS(3)) dut (
        .CLOCK(CLOCK), .RESET(RESET), .i_switches(switches), .i_switchReg(switchReg),
        .o_lamps(lamps)
    );

    always #4 CLOCK = ~CLOCK;               // 8 ns period

    ////////////////////
    // console helpers
    ////////////////////
    task automatic pressRelease(input panelSwitch_t sw, input word_t sr);
        @(posedge CLOCK);
        #1;
        switchReg = sr;
        switches  = sw;
        repeat (8) @(posedge CLOCK);        // longer than the debounce count
        #1;
        switches  = '0;                     // release gives the strobe
    endtask

    task automatic waitRun(input logic level);
        int count;
        count = 0;
        @(negedge CLOCK);
        while (lamps.run !== level && count < 200) begin
            @(negedge CLOCK);
            count++;
        end
        if (lamps.run !== level) begin
            $display("%0t ns: timeout, run lamp never went to %0d", $time, level);
            $display("Errors found");
            $finish;
        end
    endtask

    task automatic console(input panelSwitch_t sw, input word_t sr);
        pressRelease(sw, sr);
        waitRun(1'b1);                      // console cycles light run too
        waitRun(1'b0);
    endtask

    ////////////////////
    // compare tasks
    ////////////////////
    task automatic checkWord(input word_t got, input word_t exp, input string name);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s is %o, expected %o", $time, name, got, exp);
            errors++;
            testErrors++;
        end
    endtask

    task automatic checkAcLink(input acLink_t got, input acLink_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: link/ac is %b/%o, expected %b/%o",
                     $time, got.link, got.ac, exp.link, exp.ac);
            errors++;
            testErrors++;
        end
    endtask

    task automatic checkLamps(input frontLamps_t got, input frontLamps_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t ns: o_lamps is %h, expected %h", $time, got, exp);
            errors++;
            testErrors++;
        end
    endtask

    task automatic endTest(input string name);
        tests++;
        if (testErrors != 0) begin
            failedTests++;
        end
        $display("test %-12s %s", name, (testErrors == 0) ? "passed" : "FAILED");
        testErrors = 0;
    endtask

    // deposit, run from the start address, then look at AC, link and 0300
    task automatic runProgram(input progRow_t row);
        console(swLdad, 12'o0200);
        for (int k = 0; k < 8; k++) begin
            console(swDep, row.prog[k]);
        end
        console(swLdad, 12'o0300);
        console(swDep, row.operand);
        console(swLdad, row.start);
        console(swStart, row.sr);           // waits for the HLT
        checkAcLink(acLink_t'({lamps.link, lamps.ac}), row.expAcLink);
        console(swLdad, 12'o0300);          // LDAD also reads the word
        checkWord(lamps.mb, row.expMem, "mb at 0300");
    endtask

    ////////////////////
    // program table
    ////////////////////
    task automatic fillTable();
        // memory reference, data words at 0206 and 0207
        tbl[0]  = {{12'o1206, 12'o0300, hlt, hlt, hlt, hlt, 12'o0707, hlt},        // AND
                   12'o0200, 12'o5252, 12'o0000, 1'b0, 12'o0202, 12'o5252};
        tbl[1]  = {{12'o1206, 12'o1300, hlt, hlt, hlt, hlt, 12'o7000, hlt},        // TAD carry
                   12'o0200, 12'o1234, 12'o0000, 1'b1, 12'o0234, 12'o1234};
        tbl[2]  = {{12'o2300, 12'o7001, hlt, hlt, hlt, hlt, hlt, hlt},             // ISZ skip
                   12'o0200, 12'o7777, 12'o0000, 1'b0, 12'o0000, 12'o0000};
        tbl[3]  = {{12'o1206, 12'o3300, hlt, hlt, hlt, hlt, 12'o1357, hlt},        // DCA
                   12'o0200, 12'o4444, 12'o0000, 1'b0, 12'o0000, 12'o1357};
        tbl[4]  = {{12'o4204, hlt, hlt, hlt, 12'o0000, 12'o1204, 12'o3300, 12'o5604}, // JMS
                   12'o0200, 12'o0000, 12'o0000, 1'b0, 12'o0000, 12'o0201};
        tbl[5]  = {{12'o1207, 12'o3010, 12'o5410, hlt, 12'o1010, 12'o3300, hlt, 12'o0203},
                   12'o0200, 12'o0000, 12'o0000, 1'b0, 12'o0000, 12'o0204};    // JMP I 10
        // group 1 on the operand loaded by TAD
        tbl[6]  = {{12'o1300, 12'o7200, hlt, hlt, hlt, hlt, hlt, hlt},             // CLA
                   12'o0200, 12'o1234, 12'o0000, 1'b0, 12'o0000, 12'o1234};
        tbl[7]  = {{12'o1300, 12'o7040, hlt, hlt, hlt, hlt, hlt, hlt},             // CMA
                   12'o0200, 12'o1234, 12'o0000, 1'b0, 12'o6543, 12'o1234};
        tbl[8]  = {{12'o1300, 12'o7001, hlt, hlt, hlt, hlt, hlt, hlt},             // IAC
                   12'o0200, 12'o7777, 12'o0000, 1'b1, 12'o0000, 12'o7777};
        tbl[9]  = {{12'o1300, 12'o7004, hlt, hlt, hlt, hlt, hlt, hlt},             // RAL
                   12'o0200, 12'o4001, 12'o0000, 1'b1, 12'o0002, 12'o4001};
        tbl[10] = {{12'o1300, 12'o7012, hlt, hlt, hlt, hlt, hlt, hlt},             // RTR
                   12'o0200, 12'o0003, 12'o0000, 1'b1, 12'o4000, 12'o0003};
        tbl[11] = {{12'o1300, 12'o7002, hlt, hlt, hlt, hlt, hlt, hlt},             // BSW
                   12'o0200, 12'o1234, 12'o0000, 1'b0, 12'o3412, 12'o1234};
        // group 2, ISZ 0300 runs only when not skipped
        tbl[12] = {{12'o1300, 12'o7500, 12'o2300, hlt, hlt, hlt, hlt, hlt},        // SMA
                   12'o0200, 12'o4000, 12'o0000, 1'b0, 12'o4000, 12'o4000};
        tbl[13] = {{12'o1300, 12'o7510, 12'o2300, hlt, hlt, hlt, hlt, hlt},        // SPA
                   12'o0200, 12'o4000, 12'o0000, 1'b0, 12'o4000, 12'o4001};
        tbl[14] = {{12'o1300, 12'o7440, 12'o2300, hlt, hlt, hlt, hlt, hlt},        // SZA
                   12'o0200, 12'o0000, 12'o0000, 1'b0, 12'o0000, 12'o0000};
        tbl[15] = {{12'o1300, 12'o7450, 12'o2300, hlt, hlt, hlt, hlt, hlt},        // SNA
                   12'o0200, 12'o0000, 12'o0000, 1'b0, 12'o0000, 12'o0001};
        tbl[16] = {{12'o7020, 12'o7420, 12'o2300, hlt, hlt, hlt, hlt, hlt},        // SNL
                   12'o0200, 12'o0017, 12'o0000, 1'b1, 12'o0000, 12'o0017};
        tbl[17] = {{12'o7020, 12'o7430, 12'o2300, hlt, hlt, hlt, hlt, hlt},        // SZL
                   12'o0200, 12'o0017, 12'o0000, 1'b1, 12'o0000, 12'o0020};
        tbl[18] = {{12'o7604, hlt, hlt, hlt, hlt, hlt, hlt, hlt},                  // CLA OSR
                   12'o0200, 12'o0000, 12'o2525, 1'b0, 12'o2525, 12'o0000};
    endtask

    initial begin
        CLOCK       = 1'b0;
        RESET       = 1'b1;
        switches    = '0;
        switchReg   = '0;
        seed        = 14933;
        errors      = 0;
        testErrors  = 0;
        tests       = 0;
        failedTests = 0;
        fillTable();
        repeat (10) @(posedge CLOCK);
        #1;
        RESET = 1'b0;
        @(negedge CLOCK);
        checkLamps(lamps, '0);              // every register and flag cleared
        endTest("reset");

        // deposit and examine round trip at 0400
        for (int k = 0; k < 8; k++) begin
            randWords[k] = word_t'($random(seed));
        end
        console(swLdad, 12'o0400);
        for (int k = 0; k < 8; k++) begin
            console(swDep, randWords[k]);
        end
        console(swLdad, 12'o0400);
        for (int k = 0; k < 8; k++) begin
            console(swExam, 12'o0000);
            checkWord(lamps.mb, randWords[k], "mb");
            checkWord(lamps.ma, word_t'(12'o0400 + k), "ma");
        end
        endTest("dep/exam");

        for (int i = 0; i < numRows; i++) begin
            runProgram(tbl[i]);
            endTest($sformatf("program %0d", i));
        end

        // HLT, IAC, HLT and then CONT past the first halt
        console(swLdad, 12'o0200);
        console(swDep, hlt);
        console(swDep, 12'o7001);
        console(swDep, hlt);
        console(swLdad, 12'o0200);
        console(swStart, 12'o0000);
        checkAcLink(acLink_t'({lamps.link, lamps.ac}), {1'b0, 12'o0000});
        console(swCont, 12'o0000);
        checkAcLink(acLink_t'({lamps.link, lamps.ac}), {1'b0, 12'o0001});
        checkWord(lamps.ma, 12'o0202, "ma");
        endTest("cont");

        // JMP . loops until the stop switch
        console(swLdad, 12'o0200);
        console(swDep, 12'o5200);
        console(swLdad, 12'o0200);
        pressRelease(swStart, 12'o0000);
        waitRun(1'b1);
        @(posedge CLOCK);
        #1;
        switches = swStop;
        waitRun(1'b0);
        stopLamps    = '0;
        stopLamps.ma = 12'o0200;
        stopLamps.mb = 12'o5200;
        stopLamps.ir = OPC_JMP;
        checkLamps(lamps, stopLamps);
        @(posedge CLOCK);
        #1;
        switches = '0;
        endTest("stop");

        $display("%0d tests, %0d failed, %0d mismatches", tests, failedTests, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* testbench/pdp8Top_checker.sv */
// sequencer protocol checks: time-state order, exclusive cycle lamps, core write timing
`timescale 1ns/1ns

module pdp8Top_checker import pdp8Pkg::*; (
    input logic        CLOCK,
    input logic        RESET,
    input majState_e   i_majState,
    input timeState_e  i_timeState,
    input logic        i_wrEn,
    input frontLamps_t i_lamps
);

    // a running cycle always leaves IDLE for TS1
    idleToTs1: assert property (@(posedge CLOCK) disable iff (RESET)
        (i_timeState == TS_IDLE && i_majState != MS_HALT) |=> (i_timeState == TS_TS1))
        else $error("TS1 did not follow IDLE in a running cycle");

    // at most one of fetch, defer, exec
    // defer and exec only follow a fetch or defer cycle
    oneCycleLamp: assert property (@(posedge CLOCK) disable iff (RESET)
        $onehot0({i_lamps.fetch, i_lamps.defer, i_lamps.exec}) &&
        (!$rose(i_lamps.defer) || $past(i_lamps.fetch)) &&
        (!$rose(i_lamps.exec) || $past(i_lamps.fetch || i_lamps.defer)))
        else $error("cycle lamps overlap or out of order");

    // core write only in TS3 of a running cycle, one clock wide
    writeInTs3: assert property (@(posedge CLOCK) disable iff (RESET)
        i_wrEn |-> (i_timeState == TS_TS3) && (i_majState != MS_HALT) && !$past(i_wrEn))
        else $error("core write enable outside TS3 of a running cycle");

endmodule

bind cpuSequencer pdp8Top_checker seqCheck (
    .CLOCK(CLOCK), .RESET(RESET), .i_majState(majState), .i_timeState(timeState),
    .i_wrEn(o_wrEn), .i_lamps(o_lamps)
);

/* verilog/coreMemory.sv */
// PDP-8 local core: 4096 words with one-clock synchronous read and write
`timescale 1ns/1ns

module coreMemory import pdp8Pkg::*; (
    input  logic  CLOCK,
    input  word_t i_addr,                   // MA from the sequencer
    input  word_t i_wrData,                 // MB from the sequencer
    input  logic  i_wrEn,                   // high in TS3 only
    output word_t o_rdData
);

    word_t core [0:4095];                   // maps onto block RAM

    always_ff @(posedge CLOCK) begin
        if (i_wrEn) begin
            core[i_addr] <= i_wrData;       // write back at end of TS3
        end
        o_rdData <= core[i_addr];           // valid during TS1, address held through IDLE
    end

endmodule

/* verilog/cpuSequencer.sv */
// PDP-8 sequencer: major and time states, processor registers and console service
`timescale 1ns/1ns

module cpuSequencer import pdp8Pkg::*; (
    input  logic        CLOCK,
    input  logic        RESET,
    input  panelCmd_t   i_cmd,
    input  logic        i_stop,             // stop or step switch held
    input  word_t       i_switchReg,
    input  word_t       i_rdData,
    input  mrefResult_t i_mref,
    input  opResult_t   i_op,
    output word_t       o_addr,
    output word_t       o_wrData,
    output logic        o_wrEn,
    output instrWord_u  o_mb,
    output acLink_t     o_acLink,
    output word_t       o_ma,
    output frontLamps_t o_lamps
);

    majState_e  majState, nextMaj, endState;
    timeState_e timeState;
    acLink_t    acLink, acLinkNext;
    word_t      pc, pcNext, ma, maNext;
    instrWord_u mb;
    logic [2:0] ir;

    assign o_addr   = ma;
    assign o_wrData = mb;
    assign o_wrEn   = (timeState == TS_TS3);    // core restore or modified MB
    assign o_mb     = mb;
    assign o_acLink = acLink;
    assign o_ma     = ma;

    // state after the last cycle of an instruction
    always_comb begin
        if (i_stop || (majState == MS_FETCH && i_op.halt)) begin
            endState = MS_HALT;
        end else begin
            endState = MS_FETCH;
        end
    end

    // TS4 register updates
    always_comb begin
        pcNext     = pc;
        maNext     = ma;
        acLinkNext = acLink;
        case (majState)
            MS_FETCH: case (ir)
                OPC_JMP: begin
                    if (mb.mref.indirect) maNext = i_mref.effAddr;  // pointer address
                    else                  pcNext = i_mref.effAddr;
                end
                OPC_IOT: pcNext = pc;       // no I/O bus, plain fetch
                OPC_OPR: begin
                    acLinkNext = i_op.acLink;
                    if (i_op.skip) pcNext = pc + 12'd1;
                end
                default: maNext = i_mref.effAddr;   // AND TAD ISZ DCA JMS
            endcase
            MS_DEFER: begin
                if (ir == OPC_JMP) pcNext = mb;     // jump through pointer
                else               maNext = mb;
            end
            MS_EXEC: case (ir)
                OPC_AND: acLinkNext.ac = i_mref.andAc;
                OPC_TAD: acLinkNext    = i_mref.tadSum;
                OPC_ISZ: if (word_t'(mb) == 12'o0000) pcNext = pc + 12'd1;
                OPC_DCA: acLinkNext.ac = 12'o0000;
                OPC_JMS: pcNext        = ma + 12'd1;    // past the stored return
                default: pcNext        = pc;
            endcase
            default: pcNext = pc;           // console cycles leave registers alone
        endcase
    end

    always_ff @(posedge CLOCK) begin
        if (RESET) begin
            majState  <= MS_HALT;
            nextMaj   <= MS_HALT;
            timeState <= TS_IDLE;
            acLink    <= '0;
            pc        <= '0;
            ma        <= '0;
            mb        <= '0;
            ir        <= '0;
        end else begin
            case (timeState)
                ////////////////////
                // idle, console
                ////////////////////
                TS_IDLE: begin
                    if (majState != MS_HALT) begin
                        timeState <= TS_TS1;    // MA has been stable for a clock
                    end else if (i_cmd.ldad) begin
                        pc       <= i_switchReg;
                        ma       <= i_switchReg;
                        majState <= MS_EXAM;
                    end else if (i_cmd.exam) begin
                        ma       <= pc;
                        pc       <= pc + 12'd1;
                        majState <= MS_EXAM;
                    end else if (i_cmd.dep) begin
                        ma       <= pc;
                        pc       <= pc + 12'd1;
                        majState <= MS_DEPOS;
                    end else if (i_cmd.cont) begin
                        ma       <= pc;
                        majState <= MS_FETCH;
                    end else if (i_cmd.start) begin
                        acLink   <= '0;         // START clears AC and link
                        ma       <= pc;
                        majState <= MS_FETCH;
                    end
                end
                TS_TS1: begin
                    mb        <= i_rdData;      // read word from core
                    timeState <= TS_TS2;
                end
                ////////////////////
                // modify MB
                ////////////////////
                TS_TS2: begin
                    case (majState)
                        MS_FETCH: begin
                            ir <= mb.mref.opcode;
                            pc <= pc + 12'd1;
                        end
                        MS_DEFER: if (i_mref.autoIndex) mb <= i_mref.incMb;
                        MS_EXEC: case (ir)
                            OPC_ISZ: mb <= i_mref.incMb;
                            OPC_DCA: mb <= acLink.ac;
                            OPC_JMS: mb <= pc;  // return address
                            default: mb <= mb;
                        endcase
                        MS_DEPOS: mb <= i_switchReg;
                        default:  mb <= mb;
                    endcase
                    timeState <= TS_TS3;
                end
                TS_TS3: begin                   // core write happens this clock
                    case (majState)
                        MS_FETCH: begin
                            if (ir == OPC_IOT || ir == OPC_OPR) nextMaj <= endState;
                            else if (i_mref.needDefer)          nextMaj <= MS_DEFER;
                            else if (ir == OPC_JMP)             nextMaj <= endState;
                            else                                nextMaj <= MS_EXEC;
                        end
                        MS_DEFER: begin
                            if (ir == OPC_JMP) nextMaj <= endState;
                            else               nextMaj <= MS_EXEC;
                        end
                        MS_EXEC: nextMaj <= endState;
                        default: nextMaj <= MS_HALT;    // console cycle done
                    endcase
                    timeState <= TS_TS4;
                end
                TS_TS4: begin
                    pc       <= pcNext;
                    acLink   <= acLinkNext;
                    ma       <= (nextMaj == MS_FETCH) ? pcNext : maNext;
                    majState <= nextMaj;
                    timeState <= TS_IDLE;
                end
                default: timeState <= TS_IDLE;
            endcase
        end
    end

    always_comb begin
        o_lamps.ac    = acLink.ac;
        o_lamps.link  = acLink.link;
        o_lamps.ma    = ma;
        o_lamps.mb    = mb;
        o_lamps.ir    = ir;
        o_lamps.run   = (majState != MS_HALT);  // console cycles light it too
        o_lamps.fetch = (majState == MS_FETCH);
        o_lamps.defer = (majState == MS_DEFER);
        o_lamps.exec  = (majState == MS_EXEC);
    end

endmodule

/* verilog/memRefUnit.sv */
// PDP-8 memory-reference decode: effective address, defer and auto-index flags, execute results
`timescale 1ns/1ns

module memRefUnit import pdp8Pkg::*; (
    input  instrWord_u  i_mb,
    input  word_t       i_ma,
    input  acLink_t     i_acLink,
    output mrefResult_t o_res
);

    word_t mbWord;                          // MB as a plain data word

    assign mbWord = i_mb;

    always_comb begin
        // page bits from MA for current page, else page zero
        o_res.effAddr   = {(i_mb.mref.currentPage ? i_ma[11:7] : 5'b0), i_mb.mref.offset};

        // IOT and OPR use bit 8 for other things
        o_res.needDefer = i_mb.mref.indirect &&
                          (i_mb.mref.opcode != OPC_IOT) &&
                          (i_mb.mref.opcode != OPC_OPR);

        o_res.autoIndex = (i_ma[11:3] == 9'o001);   // 0010..0017

        o_res.andAc     = i_acLink.ac & mbWord;

        // carry out of ac flips the link
        o_res.tadSum    = {i_acLink.link, i_acLink.ac} + {1'b0, mbWord};

        o_res.incMb     = mbWord + 12'd1;   // ISZ and auto-index
    end

endmodule

/* verilog/operateUnit.sv */
// PDP-8 operate instructions: group 1 microcode, group 2 skips, OSR and HLT
`timescale 1ns/1ns

module operateUnit import pdp8Pkg::*; (
    input  instrWord_u i_mb,
    input  acLink_t    i_acLink,
    input  word_t      i_switchReg,
    output opResult_t  o_res
);

    logic [7:0] micro;
    acLink_t    g1Clr;                      // after CLA/CLL and CMA/CML
    acLink_t    g1Inc;                      // after IAC
    acLink_t    g1Rot;                      // after the rotate code
    logic       g2Skip;
    word_t      g2Ac;

    assign micro = i_mb.opr.micro;

    ////////////////////
    // group 1
    ////////////////////
    always_comb begin
        g1Clr.link = (micro[6] ? 1'b0 : i_acLink.link) ^ micro[4];     // CLL, CML
        g1Clr.ac   = (micro[7] ? 12'o0000 : i_acLink.ac) ^ {12{micro[5]}}; // CLA, CMA
        g1Inc      = g1Clr + {12'd0, micro[0]};                        // IAC carries into link
        case (micro[3:1])                   // RAR RAL BSW
            3'd1: g1Rot = {g1Inc.link, g1Inc.ac[5:0], g1Inc.ac[11:6]};     // BSW
            3'd2: g1Rot = {g1Inc.ac, g1Inc.link};                          // RAL
            3'd3: g1Rot = {g1Inc.ac[10:0], g1Inc.link, g1Inc.ac[11]};      // RTL
            3'd4: g1Rot = {g1Inc.ac[0], g1Inc.link, g1Inc.ac[11:1]};       // RAR
            3'd5: g1Rot = {g1Inc.ac[1:0], g1Inc.link, g1Inc.ac[11:2]};     // RTR
            default: g1Rot = g1Inc;         // no rotate
        endcase
    end

    ////////////////////
    // group 2
    ////////////////////
    assign g2Skip = ((micro[6] & i_acLink.ac[11]) |             // SMA
                     (micro[5] & (i_acLink.ac == 12'o0000)) |   // SZA
                     (micro[4] & i_acLink.link)) ^              // SNL
                    micro[3];                                   // reverse sense

    assign g2Ac = (micro[7] ? 12'o0000 : i_acLink.ac) | (micro[2] ? i_switchReg : 12'o0000);

    always_comb begin
        o_res.acLink = i_acLink;            // unchanged unless an operate applies
        o_res.skip   = 1'b0;
        o_res.halt   = 1'b0;
        if (i_mb.opr.opcode == OPC_OPR) begin
            if (!i_mb.opr.group) begin
                o_res.acLink = g1Rot;
            end else if (!micro[0]) begin   // bit 0 set is group 3, a no-op here
                o_res.acLink.ac = g2Ac;
                o_res.skip      = g2Skip;
                o_res.halt      = micro[1]; // HLT
            end
        end
    end

endmodule

/* verilog/panelSwitches.sv */
// front panel momentary switches: debounce and one-cycle command strobe on release
`timescale 1ns/1ns

module panelSwitches import pdp8Pkg::*; #(
    parameter int DEBOUNCE_BITS = 20
) (
    input  logic         CLOCK,
    input  logic         RESET,
    input  panelSwitch_t i_switches,
    output panelCmd_t    o_cmd
);

    logic [DEBOUNCE_BITS-1:0] count;        // runs while any switch is held
    logic                     debounced;    // count complete
    panelCmd_t                held;         // momentary switches only
    panelCmd_t                lastHeld;     // level one clock ago

    assign debounced = count[DEBOUNCE_BITS-1];

    always_comb begin
        held.start = i_switches.start;
        held.cont  = i_switches.cont;
        held.ldad  = i_switches.ldad;
        held.exam  = i_switches.exam;
        held.dep   = i_switches.dep;
    end

    always_ff @(posedge CLOCK) begin
        if (RESET) begin
            count    <= '0;
            lastHeld <= '0;
            o_cmd    <= '0;
        end else begin
            if (held == '0) begin
                count <= '0;                // nothing pressed, start over
            end else if (!debounced) begin
                count <= count + 1'b1;      // stops at the limit
            end
            lastHeld <= held;
            // falling edge while stable gives one strobe
            o_cmd <= debounced ? panelCmd_t'(lastHeld & ~held) : '0;
        end
    end

endmodule

/* verilog/pdp8Pkg.sv */
// PDP-8 shared types: machine word, cycle states, instruction views and signal bundles
package pdp8Pkg;

    typedef logic [11:0] word_t;                    // one 12-bit machine word

    typedef enum logic [3:0] {
        MS_HALT, MS_FETCH, MS_DEFER, MS_EXEC, MS_DEPOS, MS_EXAM
    } majState_e;                                   // major state of the memory cycle

    typedef enum logic [2:0] {
        TS_IDLE, TS_TS1, TS_TS2, TS_TS3, TS_TS4
    } timeState_e;                                  // time state inside one memory cycle

    // opcode field values
    localparam logic [2:0] OPC_AND = 3'd0;
    localparam logic [2:0] OPC_TAD = 3'd1;
    localparam logic [2:0] OPC_ISZ = 3'd2;
    localparam logic [2:0] OPC_DCA = 3'd3;
    localparam logic [2:0] OPC_JMS = 3'd4;
    localparam logic [2:0] OPC_JMP = 3'd5;
    localparam logic [2:0] OPC_IOT = 3'd6;
    localparam logic [2:0] OPC_OPR = 3'd7;

    typedef struct packed {
        logic [2:0] opcode;
        logic       indirect;                       // bit 8, defer through the addressed word
        logic       currentPage;                    // bit 7, page of MA instead of page zero
        logic [6:0] offset;
    } mrefView_t;

    typedef struct packed {
        logic [2:0] opcode;
        logic       group;                          // 0 = group 1, 1 = group 2
        logic [7:0] micro;
    } oprView_t;

    typedef union packed {
        mrefView_t mref;
        oprView_t  opr;
    } instrWord_u;

    typedef struct packed { logic link; word_t ac; } acLink_t;

    typedef struct packed { acLink_t acLink; logic skip; logic halt; } opResult_t;

    typedef struct packed {
        word_t   effAddr;
        logic    needDefer;
        logic    autoIndex;                         // MA in 0010..0017
        word_t   andAc;
        acLink_t tadSum;
        word_t   incMb;
    } mrefResult_t;

    typedef struct packed {
        logic start, cont, ldad, exam, dep, stop, step;
    } panelSwitch_t;

    typedef struct packed { logic start, cont, ldad, exam, dep; } panelCmd_t;

    typedef struct packed {
        word_t      ac;
        logic       link;
        word_t      ma;
        word_t      mb;
        logic [2:0] ir;
        logic       run, fetch, defer, exec;
    } frontLamps_t;

endpackage

/* verilog/pdp8Top.sv */
// PDP-8/L style core top level: panel debounce, sequencer, decode units and local core
`timescale 1ns/1ns

module pdp8Top import pdp8Pkg::*; #(
    parameter int DEBOUNCE_BITS = 20
) (
    input  logic         CLOCK,
    input  logic         RESET,
    input  panelSwitch_t i_switches,
    input  word_t        i_switchReg,
    output frontLamps_t  o_lamps
);

    panelCmd_t   cmd;
    word_t       addr, wrData, rdData, ma;
    logic        wrEn;
    instrWord_u  mb;
    acLink_t     acLink;
    mrefResult_t mref;
    opResult_t   op;

    panelSwitches #(.DEBOUNCE_BITS(DEBOUNCE_BITS)) panel (
        .CLOCK(CLOCK), .RESET(RESET), .i_switches(i_switches), .o_cmd(cmd)
    );

    coreMemory core (
        .CLOCK(CLOCK), .i_addr(addr), .i_wrData(wrData), .i_wrEn(wrEn), .o_rdData(rdData)
    );

    memRefUnit mrefUnit (.i_mb(mb), .i_ma(ma), .i_acLink(acLink), .o_res(mref));

    operateUnit oprUnit (.i_mb(mb), .i_acLink(acLink), .i_switchReg(i_switchReg), .o_res(op));

    cpuSequencer seq (
        .CLOCK(CLOCK), .RESET(RESET), .i_cmd(cmd),
        .i_stop(i_switches.stop | i_switches.step),     // either one halts at end of instruction
        .i_switchReg(i_switchReg), .i_rdData(rdData), .i_mref(mref), .i_op(op),
        .o_addr(addr), .o_wrData(wrData), .o_wrEn(wrEn), .o_mb(mb),
        .o_acLink(acLink), .o_ma(ma), .o_lamps(o_lamps)
    );

endmodule
